// File: filelist.f
+incdir+hw
hw/axil_pkg.sv
hw/iob_pkg.sv
hw/axil2iob_bridge.sv
hw/iob_regbank.sv
hw/axil_regbank_top.sv
bench/tb_axil_regbank.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the register bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
   --top-module tb_axil_regbank -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
   exit 1
fi
exit 0

// File: bench/tb_axil_regbank.sv
`timescale 1ns/1ps
`include "axil2iob_consts.svh"

module tb_axil_regbank
   import axil_pkg::*;
();

   localparam int CLK_PERIOD = 8;
   localparam int N_TRANS    = 100;
   localparam int TIMEOUT_NS = (N_TRANS * 20 + 200) * CLK_PERIOD;

   logic     clk;
   logic     reset;
   axil_aw_t aw;
   logic     awvalid;
   logic     awready;
   axil_w_t  w;
   logic     wvalid;
   logic     wready;
   axil_b_t  b;
   logic     bvalid;
   logic     bready;
   axil_ar_t ar;
   logic     arvalid;
   logic     arready;
   axil_r_t  r;
   logic     rvalid;
   logic     rready;

   // Expected register contents
   logic [`AXIL_DATA_W-1:0] model [`REGBANK_NREGS];
   axil_r_t exp_r_q [$];
   axil_b_t exp_b_q [$];
   int      errors = 0;
   int      checks = 0;
   int      n_tests = 0;
   time     t_aw;
   time     t_rdone;
   logic    r_wait = 1'b0;
   logic    b_wait = 1'b0;
   axil_r_t r_held;

   axil_regbank_top axil_regbank_top_inst (
      .clk_i    (clk),
      .reset_i  (reset),
      .aw_i     (aw),
      .awvalid_i(awvalid),
      .awready_o(awready),
      .w_i      (w),
      .wvalid_i (wvalid),
      .wready_o (wready),
      .b_o      (b),
      .bvalid_o (bvalid),
      .bready_i (bready),
      .ar_i     (ar),
      .arvalid_i(arvalid),
      .arready_o(arready),
      .r_o      (r),
      .rvalid_o (rvalid),
      .rready_i (rready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Applies a write or a read to the model, returns the word seen by a read
   function automatic logic [`AXIL_DATA_W-1:0] ref_access(
      input logic [`AXIL_ADDR_W-1:0] addr,
      input logic [`AXIL_DATA_W-1:0] data,
      input logic [`AXIL_STRB_W-1:0] strb,
      input logic                    wr
   );
      logic [2:0] idx;
      idx = addr[4:2];
      if (idx == 3'(`REGBANK_NREGS - 1)) begin
         return `REGBANK_ID_VAL;
      end
      if (wr) begin
         for (int i = 0; i < `AXIL_STRB_W; i++) begin
            if (strb[i]) begin
               model[idx][8*i +: 8] = data[8*i +: 8];
            end
         end
      end
      return model[idx];
   endfunction

   function automatic logic [`AXIL_ADDR_W-1:0] word_addr(input int i);
      return {i[2:0], 2'b00};
   endfunction

   task automatic check_rdata(input axil_r_t exp, input axil_r_t act);
      checks++;
      if (act.data !== exp.data) begin
         $display("FAIL r_o.data expected %h got %h", exp.data, act.data);
         errors++;
      end
      if (act.resp !== exp.resp) begin
         $display("FAIL r_o.resp expected %h got %h", exp.resp, act.resp);
         errors++;
      end
   endtask

   task automatic check_bresp(input axil_b_t exp, input axil_b_t act);
      checks++;
      if (act.resp !== exp.resp) begin
         $display("FAIL b_o.resp expected %h got %h", exp.resp, act.resp);
         errors++;
      end
   endtask

   task automatic axil_write(
      input logic [`AXIL_ADDR_W-1:0] addr,
      input logic [`AXIL_DATA_W-1:0] data,
      input logic [`AXIL_STRB_W-1:0] strb
   );
      axil_b_t     exp_b;
      int unsigned hold;
      aw.addr = addr;
      w.data  = data;
      w.strb  = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge clk);
      while (!(awready && wready)) @(negedge clk);
      t_aw = $time;
      void'(ref_access(addr, data, strb, 1'b1));
      exp_b.resp = `AXIL_RESP_OKAY;
      exp_b_q.push_back(exp_b);
      @(posedge clk);
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      // Random back-pressure on B
      hold = $urandom_range(0, 5);
      repeat (hold) begin
         @(posedge clk);
         #1;
      end
      bready = 1'b1;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      @(posedge clk);
      #1;
      bready = 1'b0;
   endtask

   task automatic axil_read(input logic [`AXIL_ADDR_W-1:0] addr);
      axil_r_t     exp_r;
      int unsigned hold;
      ar.addr = addr;
      arvalid = 1'b1;
      @(negedge clk);
      while (!arready) @(negedge clk);
      exp_r.data = ref_access(addr, '0, '0, 1'b0);
      exp_r.resp = `AXIL_RESP_OKAY;
      exp_r_q.push_back(exp_r);
      @(posedge clk);
      #1;
      arvalid = 1'b0;
      hold = $urandom_range(0, 5);
      repeat (hold) begin
         @(posedge clk);
         #1;
      end
      rready = 1'b1;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      t_rdone = $time;
      @(posedge clk);
      #1;
      rready = 1'b0;
   endtask

   task automatic report_test(input string name, input int errs_before);
      n_tests++;
      $display("test %0d %s: %s", n_tests, name, (errors == errs_before) ? "ok" : "failed");
   endtask

   // Response checker, sampled mid-cycle where the bus is stable
   always @(negedge clk) begin
      if (!reset) begin
         if (rvalid && rready) begin
            if (exp_r_q.size() == 0) begin
               $display("Read response arrived with no read outstanding");
               errors++;
            end else begin
               check_rdata(exp_r_q.pop_front(), r);
            end
         end
         if (bvalid && bready) begin
            if (exp_b_q.size() == 0) begin
               $display("Write response arrived with no write outstanding");
               errors++;
            end else begin
               check_bresp(exp_b_q.pop_front(), b);
            end
         end
         if (r_wait && !(rvalid && r == r_held)) begin
            $display("Read response dropped or changed while waiting for rready");
            errors++;
         end
         if (b_wait && !bvalid) begin
            $display("Write response dropped while waiting for bready");
            errors++;
         end
         if ((bvalid || rvalid) && (arready || awready || wready)) begin
            $display("Address or data ready high while a response was pending");
            errors++;
         end
         r_wait = rvalid && !rready;
         r_held = r;
         b_wait = bvalid && !bready;
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish in the time allowed");
      errors++;
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      logic [2:0]              idx;
      logic [`AXIL_ADDR_W-1:0] a;
      int                      errs;
      void'($urandom(32'h712d1fbf));
      reset   = 1'b1;
      aw      = '0;
      w       = '0;
      ar      = '0;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      arvalid = 1'b0;
      rready  = 1'b0;
      for (int i = 0; i < `REGBANK_NREGS; i++) begin
         model[i] = '0;
      end

      errs = errors;
      repeat (4) begin
         @(posedge clk);
         #1;
         if (bvalid !== 1'b0 || rvalid !== 1'b0) begin
            $display("Response valid high during reset");
            errors++;
         end
      end
      reset = 1'b0;
      @(negedge clk);
      if (bvalid !== 1'b0 || rvalid !== 1'b0) begin
         $display("Response valid high right after reset");
         errors++;
      end
      @(posedge clk);
      #1;
      for (int i = 0; i < `REGBANK_NREGS; i++) begin
         axil_read(word_addr(i));
      end
      report_test("reset values", errs);

      errs = errors;
      for (int i = 0; i < `REGBANK_NREGS - 1; i++) begin
         axil_write(word_addr(i), $urandom, 4'hF);
      end
      for (int i = 0; i < `REGBANK_NREGS - 1; i++) begin
         axil_read(word_addr(i));
      end
      report_test("full word writes", errs);

      errs = errors;
      repeat (16) begin
         idx = 3'($urandom_range(0, 6));
         axil_write({idx, 2'b00}, $urandom, 4'($urandom_range(1, 14)));
         axil_read({idx, 2'b00});
      end
      // Zero strobe leaves the word alone
      axil_write(word_addr(3), $urandom, 4'h0);
      axil_read(word_addr(3));
      report_test("partial strobe writes", errs);

      errs = errors;
      axil_write(word_addr(7), 32'hFFFF_FFFF, 4'hF);
      axil_read(word_addr(7));
      axil_write(word_addr(7), $urandom, 4'h3);
      axil_read(word_addr(7));
      report_test("identification register", errs);

      errs = errors;
      repeat (12) begin
         idx = 3'($urandom_range(0, 6));
         axil_write({idx, 2'b00}, $urandom, 4'($urandom_range(1, 15)));
         axil_read({3'($urandom_range(0, 7)), 2'b00});
      end
      report_test("response back-pressure", errs);

      errs = errors;
      repeat (3) begin
         a   = {3'($urandom_range(0, 7)), 2'b00};
         idx = 3'($urandom_range(0, 6));
         fork
            axil_read(a);
            axil_write({idx, 2'b00}, $urandom, 4'hF);
         join
         if (t_aw <= t_rdone) begin
            $display("Write was accepted before the competing read had completed");
            errors++;
         end
      end
      for (int i = 0; i < `REGBANK_NREGS; i++) begin
         axil_read(word_addr(i));
      end
      report_test("read and write together", errs);

      if (exp_r_q.size() != 0 || exp_b_q.size() != 0) begin
         $display("Some responses never arrived");
         errors++;
      end
      $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: hw/axil_regbank_top.sv
`timescale 1ns/1ps

module axil_regbank_top
   import axil_pkg::*;
   import iob_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,

   // AXI-Lite slave port
   input  axil_aw_t aw_i,
   input  logic     awvalid_i,
   output logic     awready_o,
   input  axil_w_t  w_i,
   input  logic     wvalid_i,
   output logic     wready_o,
   output axil_b_t  b_o,
   output logic     bvalid_o,
   input  logic     bready_i,
   input  axil_ar_t ar_i,
   input  logic     arvalid_i,
   output logic     arready_o,
   output axil_r_t  r_o,
   output logic     rvalid_o,
   input  logic     rready_i
);

   // Bridge to bank
   logic     iob_valid;
   iob_req_t iob_req;
   logic     iob_ready;
   logic     iob_rvalid;
   iob_rsp_t iob_rsp;

   axil2iob_bridge axil2iob_bridge_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .aw_i        (aw_i),
      .awvalid_i   (awvalid_i),
      .awready_o   (awready_o),
      .w_i         (w_i),
      .wvalid_i    (wvalid_i),
      .wready_o    (wready_o),
      .b_o         (b_o),
      .bvalid_o    (bvalid_o),
      .bready_i    (bready_i),
      .ar_i        (ar_i),
      .arvalid_i   (arvalid_i),
      .arready_o   (arready_o),
      .r_o         (r_o),
      .rvalid_o    (rvalid_o),
      .rready_i    (rready_i),
      .iob_valid_o (iob_valid),
      .iob_req_o   (iob_req),
      .iob_ready_i (iob_ready),
      .iob_rvalid_i(iob_rvalid),
      .iob_rsp_i   (iob_rsp)
   );

   iob_regbank iob_regbank_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .iob_valid_i (iob_valid),
      .iob_req_i   (iob_req),
      .iob_ready_o (iob_ready),
      .iob_rvalid_o(iob_rvalid),
      .iob_rsp_o   (iob_rsp)
   );

endmodule

// File: hw/iob_regbank.sv
`timescale 1ns/1ps
`include "axil2iob_consts.svh"

module iob_regbank
   import iob_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,

   // IOb slave
   input  logic     iob_valid_i,
   input  iob_req_t iob_req_i,
   output logic     iob_ready_o,
   output logic     iob_rvalid_o,
   output iob_rsp_t iob_rsp_o
);

   localparam int IDX_W  = $clog2(`REGBANK_NREGS);
   localparam int ID_IDX = `REGBANK_NREGS - 1;
   localparam int NWR    = `REGBANK_NREGS - 1;

   // Writable registers only, the ID word is a constant
   logic [`AXIL_DATA_W-1:0] regs_q [NWR];
   logic [`AXIL_DATA_W-1:0] rdata_q;
   logic                    rvalid_q;
   logic [IDX_W-1:0]        idx;
   logic                    is_read;
   logic                    is_write;
   logic                    id_sel;

   assign iob_ready_o = 1'b1;

   // Word index from the byte address
   assign idx    = iob_req_i.addr[IDX_W+1:2];
   assign id_sel = (idx == IDX_W'(ID_IDX));

   assign is_read  = iob_valid_i && iob_ready_o && (iob_req_i.wstrb == '0);
   assign is_write = iob_valid_i && iob_ready_o && (iob_req_i.wstrb != '0);

   // Byte merge on write
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < NWR; i++) begin
            regs_q[i] <= '0;
         end
      end else if (is_write && !id_sel) begin
         for (int b = 0; b < `AXIL_STRB_W; b++) begin
            if (iob_req_i.wstrb[b]) begin
               regs_q[idx][8*b +: 8] <= iob_req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (is_read) begin
         if (id_sel) begin
            rdata_q <= `REGBANK_ID_VAL;
         end else begin
            rdata_q <= regs_q[idx];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= is_read;
      end
   end

   assign iob_rvalid_o    = rvalid_q;
   assign iob_rsp_o.rdata = rdata_q;

   a_rvalid_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
      iob_rvalid_o |-> $past(is_read));

endmodule

// File: hw/axil2iob_bridge.sv
`timescale 1ns/1ps
`include "axil2iob_consts.svh"

module axil2iob_bridge
   import axil_pkg::*;
   import iob_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,

   // AXI-Lite slave
   input  axil_aw_t aw_i,
   input  logic     awvalid_i,
   output logic     awready_o,
   input  axil_w_t  w_i,
   input  logic     wvalid_i,
   output logic     wready_o,
   output axil_b_t  b_o,
   output logic     bvalid_o,
   input  logic     bready_i,
   input  axil_ar_t ar_i,
   input  logic     arvalid_i,
   output logic     arready_o,
   output axil_r_t  r_o,
   output logic     rvalid_o,
   input  logic     rready_i,

   // IOb master
   output logic     iob_valid_o,
   output iob_req_t iob_req_o,
   input  logic     iob_ready_i,
   input  logic     iob_rvalid_i,
   input  iob_rsp_t iob_rsp_i
);

   bridge_state_e           state_q;
   bridge_state_e           state_d;
   logic                    idle;
   logic                    rd_go;
   logic                    wr_go;
   logic                    rvalid_q;
   logic [`AXIL_DATA_W-1:0] rdata_q;

   assign idle = (state_q == BR_IDLE);

   // Read has priority, write needs both AW and W at once
   assign rd_go = idle && arvalid_i && iob_ready_i;
   assign wr_go = idle && !arvalid_i && awvalid_i && wvalid_i && iob_ready_i;

   assign arready_o = idle && iob_ready_i;
   assign awready_o = wr_go;
   assign wready_o  = wr_go;

   // IOb request straight from the AXI channels
   assign iob_valid_o     = idle && (arvalid_i || (awvalid_i && wvalid_i));
   assign iob_req_o.addr  = arvalid_i ? ar_i.addr : aw_i.addr;
   assign iob_req_o.wdata = w_i.data;
   assign iob_req_o.wstrb = arvalid_i ? '0 : w_i.strb;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         BR_IDLE: begin
            if (rd_go) begin
               state_d = BR_RWAIT;
            end else if (wr_go) begin
               state_d = BR_WRESP;
            end
         end
         BR_WRESP: begin
            if (bready_i) begin
               state_d = BR_IDLE;
            end
         end
         BR_RWAIT: begin
            if (iob_rvalid_i) begin
               state_d = BR_RRESP;
            end
         end
         BR_RRESP: begin
            if (rvalid_q && rready_i) begin
               state_d = BR_IDLE;
            end
         end
         default: state_d = BR_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q  <= BR_IDLE;
         rvalid_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         // R valid one edge after the data lands in rdata_q
         rvalid_q <= (state_q == BR_RRESP) && !(rvalid_q && rready_i);
      end
   end

   // Held until the next read completes
   always_ff @(posedge clk_i) begin
      if (state_q == BR_RWAIT && iob_rvalid_i) begin
         rdata_q <= iob_rsp_i.rdata;
      end
   end

   assign bvalid_o  = (state_q == BR_WRESP);
   assign b_o.resp  = `AXIL_RESP_OKAY;
   assign rvalid_o  = rvalid_q;
   assign r_o.data  = rdata_q;
   assign r_o.resp  = `AXIL_RESP_OKAY;

   a_one_response: assert property (@(posedge clk_i) disable iff (reset_i)
      !(bvalid_o && rvalid_o));

   // Response held under back-pressure
   a_r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      (rvalid_o && !rready_i) |=> (rvalid_o && $stable(r_o)));

endmodule

// File: hw/iob_pkg.sv
`include "axil2iob_consts.svh"

package iob_pkg;

   // Request, a zero strobe means read
   typedef struct packed {
      logic [`AXIL_ADDR_W-1:0] addr;
      logic [`AXIL_DATA_W-1:0] wdata;
      logic [`AXIL_STRB_W-1:0] wstrb;
   } iob_req_t;

   // Read response payload
   typedef struct packed {
      logic [`AXIL_DATA_W-1:0] rdata;
   } iob_rsp_t;

   // Bridge FSM states
   typedef enum logic [1:0] {
      BR_IDLE  = 2'd0,
      BR_WRESP = 2'd1,
      BR_RWAIT = 2'd2,
      BR_RRESP = 2'd3
   } bridge_state_e;

endpackage

// File: hw/axil_pkg.sv
`include "axil2iob_consts.svh"

package axil_pkg;

   // Write address channel
   typedef struct packed {
      logic [`AXIL_ADDR_W-1:0] addr;
   } axil_aw_t;

   // Write data channel
   typedef struct packed {
      logic [`AXIL_DATA_W-1:0] data;
      logic [`AXIL_STRB_W-1:0] strb;
   } axil_w_t;

   // Write response channel
   typedef struct packed {
      logic [1:0] resp;
   } axil_b_t;

   // Read address channel
   typedef struct packed {
      logic [`AXIL_ADDR_W-1:0] addr;
   } axil_ar_t;

   // Read data channel
   typedef struct packed {
      logic [`AXIL_DATA_W-1:0] data;
      logic [1:0]              resp;
   } axil_r_t;

endpackage

// File: hw/axil2iob_consts.svh
`ifndef AXIL2IOB_CONSTS_SVH
`define AXIL2IOB_CONSTS_SVH

// Byte address width, enough for eight 32-bit words
`define AXIL_ADDR_W 5

// Data path width and its byte strobe
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// Register bank size
`define REGBANK_NREGS 8

// Read-only value held in the last register
`define REGBANK_ID_VAL 32'h1B0A_7E01

// AXI response codes
`define AXIL_RESP_OKAY 2'b00

`endif
